// File: common/dmem_pkg.sv
// Shared definitions for the data-side load/store path.
// Op codes, access sizes, RAM and issue queue constants.

package dmem_pkg;

  // ====================
  // Bus and RAM geometry
  // ====================
  localparam int unsigned AddrWidth   = 32;
  localparam int unsigned DataWidth   = 32;
  localparam int unsigned BeWidth     = 4;
  localparam int unsigned RamWords    = 256;
  localparam int unsigned RamIdxWidth = $clog2(RamWords);

  // ====================
  // Issue queue
  // ====================
  localparam int unsigned QueueDepth    = 4;
  localparam int unsigned QueuePtrWidth = $clog2(QueueDepth);

  // Access size as carried in the two low op bits.
  localparam logic [1:0] SizeByte = 2'b00;
  localparam logic [1:0] SizeHalf = 2'b01;
  localparam logic [1:0] SizeWord = 2'b10;

  // Bit 3 marks a store, bits 2:0 follow the RISC-V funct3 field.
  typedef enum logic [3:0] {
    LSU_LB  = 4'b0000,
    LSU_LH  = 4'b0001,
    LSU_LW  = 4'b0010,
    LSU_LBU = 4'b0100,
    LSU_LHU = 4'b0101,
    LSU_SB  = 4'b1000,
    LSU_SH  = 4'b1001,
    LSU_SW  = 4'b1010
  } lsu_op_e;

endpackage

// File: rtl/lsu_cmd_decode.sv
// Command decode stage.
// Checks op and alignment, builds byte enables and lane-replicated store data.
`timescale 1ns/100ps

module lsu_cmd_decode (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           cmd_valid_i,
  input  dmem_pkg::lsu_op_e              cmd_op_i,
  input  logic [dmem_pkg::AddrWidth-1:0] cmd_addr_i,
  input  logic [dmem_pkg::DataWidth-1:0] cmd_wdata_i,
  output logic                           dec_valid_o,
  output logic                           dec_we_o,
  output logic [dmem_pkg::AddrWidth-1:0] dec_addr_o,
  output logic [dmem_pkg::BeWidth-1:0]   dec_be_o,
  output logic [dmem_pkg::DataWidth-1:0] dec_wdata_o,
  output dmem_pkg::lsu_op_e              dec_op_o,
  output logic                           cmd_reject_o
);
  import dmem_pkg::*;

  logic                 op_legal;
  logic                 misaligned;
  logic                 accept;
  logic [1:0]           size;
  logic [BeWidth-1:0]   be_d;
  logic [DataWidth-1:0] wdata_d;

  assign size = cmd_op_i[1:0];

  always_comb begin
    case (cmd_op_i)
      LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU,
      LSU_SB, LSU_SH, LSU_SW: op_legal = 1'b1;
      default:                op_legal = 1'b0;
    endcase
  end

  // Byte enables come from the size and the low address bits.
  always_comb begin
    misaligned = 1'b0;
    be_d       = '0;
    wdata_d    = cmd_wdata_i;
    case (size)
      SizeByte: begin
        be_d    = 4'b0001 << cmd_addr_i[1:0];
        wdata_d = {4{cmd_wdata_i[7:0]}};
      end
      SizeHalf: begin
        misaligned = cmd_addr_i[0];
        be_d       = 4'b0011 << cmd_addr_i[1:0];
        wdata_d    = {2{cmd_wdata_i[15:0]}};
      end
      SizeWord: begin
        misaligned = |cmd_addr_i[1:0];
        be_d       = 4'b1111;
      end
      default: be_d = '0;
    endcase
  end

  assign accept = cmd_valid_i & op_legal & ~misaligned;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o  <= 1'b0;
      cmd_reject_o <= 1'b0;
    end else begin
      dec_valid_o  <= accept;
      cmd_reject_o <= cmd_valid_i & ~accept;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_we_o    <= cmd_op_i[3];
      dec_addr_o  <= cmd_addr_i;
      dec_be_o    <= be_d;
      dec_wdata_o <= wdata_d;
      dec_op_o    <= cmd_op_i;
    end
  end

endmodule

// File: lsu/lsu_issue_queue.sv
// Execute stage issue queue.
// Circular buffer of decoded accesses driving the req/gnt/rvalid data bus.
`timescale 1ns/100ps

module lsu_issue_queue (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           dec_valid_i,
  input  logic                           dec_we_i,
  input  logic [dmem_pkg::AddrWidth-1:0] dec_addr_i,
  input  logic [dmem_pkg::BeWidth-1:0]   dec_be_i,
  input  logic [dmem_pkg::DataWidth-1:0] dec_wdata_i,
  input  dmem_pkg::lsu_op_e              dec_op_i,
  input  logic                           dmem_gnt_i,
  input  logic                           dmem_rvalid_i,
  output logic                           dmem_req_o,
  output logic                           dmem_we_o,
  output logic [dmem_pkg::AddrWidth-1:0] dmem_addr_o,
  output logic [dmem_pkg::BeWidth-1:0]   dmem_be_o,
  output logic [dmem_pkg::DataWidth-1:0] dmem_wdata_o,
  output dmem_pkg::lsu_op_e              dmem_op_o,
  output logic                           queue_overflow_o
);
  import dmem_pkg::*;

  logic                   q_we    [QueueDepth];
  logic [AddrWidth-1:0]   q_addr  [QueueDepth];
  logic [BeWidth-1:0]     q_be    [QueueDepth];
  logic [DataWidth-1:0]   q_wdata [QueueDepth];
  lsu_op_e                q_op    [QueueDepth];

  logic [QueuePtrWidth-1:0] head_q;
  logic [QueuePtrWidth-1:0] tail_q;
  logic [QueuePtrWidth:0]   count_q;
  logic                     outstanding_q;
  logic                     full;
  logic                     push;
  logic                     pop;

  assign full = (count_q == (QueuePtrWidth + 1)'(QueueDepth));
  assign push = dec_valid_i & ~full;
  assign pop  = dmem_req_o & dmem_gnt_i;

  // Only one access may be on the bus at a time.
  assign dmem_req_o   = (count_q != '0) & ~outstanding_q;
  assign dmem_we_o    = q_we[head_q];
  assign dmem_addr_o  = q_addr[head_q];
  assign dmem_be_o    = q_be[head_q];
  assign dmem_wdata_o = q_wdata[head_q];
  assign dmem_op_o    = q_op[head_q];

  // ====================
  // Pointers and flags
  // ====================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      head_q           <= '0;
      tail_q           <= '0;
      count_q          <= '0;
      outstanding_q    <= 1'b0;
      queue_overflow_o <= 1'b0;
    end else begin
      queue_overflow_o <= dec_valid_i & full;
      if (push) begin
        tail_q <= tail_q + 1'b1;
      end
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      if (pop) begin
        outstanding_q <= 1'b1;
      end else if (dmem_rvalid_i) begin
        outstanding_q <= 1'b0;
      end
    end
  end

  // Entry storage.
  always_ff @(posedge clk_i) begin
    if (push) begin
      q_we[tail_q]    <= dec_we_i;
      q_addr[tail_q]  <= dec_addr_i;
      q_be[tail_q]    <= dec_be_i;
      q_wdata[tail_q] <= dec_wdata_i;
      q_op[tail_q]    <= dec_op_i;
    end
  end

endmodule

// File: lsu/lsu_access_tracker.sv
// Result stage access tracker.
// Records the granted access and retires it with aligned, extended load data.
`timescale 1ns/100ps

module lsu_access_tracker (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           dmem_req_i,
  input  logic                           dmem_gnt_i,
  input  logic                           dmem_we_i,
  input  logic [dmem_pkg::AddrWidth-1:0] dmem_addr_i,
  input  logic [dmem_pkg::BeWidth-1:0]   dmem_be_i,
  input  logic [dmem_pkg::DataWidth-1:0] dmem_wdata_i,
  input  dmem_pkg::lsu_op_e              dmem_op_i,
  input  logic                           dmem_rvalid_i,
  input  logic [dmem_pkg::DataWidth-1:0] dmem_rdata_i,
  input  logic                           dmem_err_i,
  output logic                           res_valid_o,
  output logic                           res_store_o,
  output logic [dmem_pkg::AddrWidth-1:0] res_addr_o,
  output logic [dmem_pkg::BeWidth-1:0]   res_be_o,
  output logic [dmem_pkg::DataWidth-1:0] res_data_o,
  output logic                           res_err_o
);
  import dmem_pkg::*;

  // ====================
  // Outstanding access
  // ====================
  logic                 out_store_q;
  logic [AddrWidth-1:0] out_addr_q;
  logic [BeWidth-1:0]   out_be_q;
  logic [DataWidth-1:0] out_wdata_q;
  lsu_op_e              out_op_q;

  logic [DataWidth-1:0] lane_data;
  logic [DataWidth-1:0] load_data;
  logic                 sign_ext;

  always_ff @(posedge clk_i) begin
    if (dmem_req_i && dmem_gnt_i) begin
      out_store_q <= dmem_we_i;
      out_addr_q  <= dmem_addr_i;
      out_be_q    <= dmem_be_i;
      out_wdata_q <= dmem_wdata_i;
      out_op_q    <= dmem_op_i;
    end
  end

  // Move the addressed lane down to bit 0.
  assign lane_data = dmem_rdata_i >> {out_addr_q[1:0], 3'b000};
  assign sign_ext  = ~out_op_q[2];

  always_comb begin
    case (out_op_q[1:0])
      SizeByte: load_data = {{(DataWidth - 8){sign_ext & lane_data[7]}}, lane_data[7:0]};
      SizeHalf: load_data = {{(DataWidth - 16){sign_ext & lane_data[15]}}, lane_data[15:0]};
      default:  load_data = lane_data;
    endcase
    if (dmem_err_i) begin
      load_data = '0;
    end
  end

  // ====================
  // Retired access
  // ====================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= dmem_rvalid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dmem_rvalid_i) begin
      res_store_o <= out_store_q;
      res_addr_o  <= out_addr_q;
      res_be_o    <= out_be_q;
      res_data_o  <= out_store_q ? out_wdata_q : load_data;
      res_err_o   <= dmem_err_i;
    end
  end

endmodule

// File: rtl/data_ram.sv
// Word-addressed data RAM slave.
// Byte-masked writes, one-cycle response, write busy cycle and range error.
`timescale 1ns/100ps

module data_ram (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic                           we_i,
  input  logic [dmem_pkg::AddrWidth-1:0] addr_i,
  input  logic [dmem_pkg::BeWidth-1:0]   be_i,
  input  logic [dmem_pkg::DataWidth-1:0] wdata_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output logic [dmem_pkg::DataWidth-1:0] rdata_o,
  output logic                           err_o
);
  import dmem_pkg::*;

  logic [DataWidth-1:0]   mem [RamWords];
  logic [AddrWidth-3:0]   word_addr;
  logic [RamIdxWidth-1:0] word_idx;
  logic                   in_range;
  logic                   busy_q;
  logic                   granted;

  assign word_addr = addr_i[AddrWidth-1:2];
  assign word_idx  = addr_i[RamIdxWidth+1:2];
  assign in_range  = (word_addr < (AddrWidth - 2)'(RamWords));

  // The RAM stalls for one cycle after it accepts a write.
  assign gnt_o   = req_i & ~busy_q;
  assign granted = req_i & gnt_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q   <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      busy_q   <= granted & we_i;
      rvalid_o <= granted;
    end
  end

  // ====================
  // Storage and response
  // ====================
  always_ff @(posedge clk_i) begin
    if (granted && we_i && in_range) begin
      for (int b = 0; b < BeWidth; b++) begin
        if (be_i[b]) begin
          mem[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (granted) begin
      err_o   <= ~in_range;
      rdata_o <= (in_range && !we_i) ? mem[word_idx] : '0;
    end
  end

endmodule

// File: rtl/lsu_subsystem_top.sv
// Load/store subsystem top level.
// Decode, issue queue, access tracker and data RAM.
`timescale 1ns/100ps

module lsu_subsystem_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           cmd_valid_i,
  input  dmem_pkg::lsu_op_e              cmd_op_i,
  input  logic [dmem_pkg::AddrWidth-1:0] cmd_addr_i,
  input  logic [dmem_pkg::DataWidth-1:0] cmd_wdata_i,
  output logic                           cmd_reject_o,
  output logic                           queue_overflow_o,
  output logic                           res_valid_o,
  output logic                           res_store_o,
  output logic [dmem_pkg::AddrWidth-1:0] res_addr_o,
  output logic [dmem_pkg::BeWidth-1:0]   res_be_o,
  output logic [dmem_pkg::DataWidth-1:0] res_data_o,
  output logic                           res_err_o
);
  import dmem_pkg::*;

  logic                 dec_valid, dec_we;
  logic [AddrWidth-1:0] dec_addr;
  logic [BeWidth-1:0]   dec_be;
  logic [DataWidth-1:0] dec_wdata;
  lsu_op_e              dec_op;

  logic                 dmem_req, dmem_gnt, dmem_we;
  logic [AddrWidth-1:0] dmem_addr;
  logic [BeWidth-1:0]   dmem_be;
  logic [DataWidth-1:0] dmem_wdata, dmem_rdata;
  lsu_op_e              dmem_op;
  logic                 dmem_rvalid, dmem_err;

  lsu_cmd_decode i_decode (
    .clk_i, .rst_ni, .cmd_valid_i, .cmd_op_i, .cmd_addr_i, .cmd_wdata_i,
    .dec_valid_o (dec_valid), .dec_we_o (dec_we), .dec_addr_o (dec_addr),
    .dec_be_o (dec_be), .dec_wdata_o (dec_wdata), .dec_op_o (dec_op),
    .cmd_reject_o
  );

  lsu_issue_queue i_issue (
    .clk_i, .rst_ni,
    .dec_valid_i (dec_valid), .dec_we_i (dec_we), .dec_addr_i (dec_addr),
    .dec_be_i (dec_be), .dec_wdata_i (dec_wdata), .dec_op_i (dec_op),
    .dmem_gnt_i (dmem_gnt), .dmem_rvalid_i (dmem_rvalid),
    .dmem_req_o (dmem_req), .dmem_we_o (dmem_we), .dmem_addr_o (dmem_addr),
    .dmem_be_o (dmem_be), .dmem_wdata_o (dmem_wdata), .dmem_op_o (dmem_op),
    .queue_overflow_o
  );

  lsu_access_tracker i_tracker (
    .clk_i, .rst_ni,
    .dmem_req_i (dmem_req), .dmem_gnt_i (dmem_gnt), .dmem_we_i (dmem_we),
    .dmem_addr_i (dmem_addr), .dmem_be_i (dmem_be), .dmem_wdata_i (dmem_wdata),
    .dmem_op_i (dmem_op), .dmem_rvalid_i (dmem_rvalid), .dmem_rdata_i (dmem_rdata),
    .dmem_err_i (dmem_err),
    .res_valid_o, .res_store_o, .res_addr_o, .res_be_o, .res_data_o, .res_err_o
  );

  data_ram i_ram (
    .clk_i, .rst_ni,
    .req_i (dmem_req), .we_i (dmem_we), .addr_i (dmem_addr), .be_i (dmem_be),
    .wdata_i (dmem_wdata), .gnt_o (dmem_gnt), .rvalid_o (dmem_rvalid),
    .rdata_o (dmem_rdata), .err_o (dmem_err)
  );

endmodule

// File: verification/tb_lsu_subsystem.sv
// Testbench for the load/store subsystem.
// Byte-array reference model, directed and random stimulus, result checker.
`timescale 1ns/100ps

module tb_lsu_subsystem;
  import dmem_pkg::*;

  typedef struct packed {
    logic        store;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] data;
    logic        err;
  } exp_res_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        cmd_valid_i;
  lsu_op_e     cmd_op_i;
  logic [31:0] cmd_addr_i;
  logic [31:0] cmd_wdata_i;
  logic        cmd_reject_o;
  logic        queue_overflow_o;
  logic        res_valid_o;
  logic        res_store_o;
  logic [31:0] res_addr_o;
  logic [3:0]  res_be_o;
  logic [31:0] res_data_o;
  logic        res_err_o;

  logic [7:0]  mirror [1024];
  exp_res_t    exp_q [$];
  logic [3:0]  legal_ops [8] = '{LSU_LB, LSU_LH, LSU_LW, LSU_LBU,
                                 LSU_LHU, LSU_SB, LSU_SH, LSU_SW};
  int          value_errors = 0;
  int          other_errors = 0;
  int          rejects_expected = 0;
  int          rejects_seen = 0;
  int          overflows_expected = 0;
  int          overflows_seen = 0;
  int          seed = 32'h84743b3a;

  lsu_subsystem_top i_lsu_subsystem_top (.*);

  always #4 clk_i = ~clk_i;

  // ====================
  // Reference model
  // ====================
  // Stores update the mirror only when in range. Loads read the addressed bytes
  // and extend them, signed for LB and LH.
  function automatic exp_res_t expected_result(input logic [3:0] op, input logic [31:0] addr,
                                               input logic [31:0] wdata);
    exp_res_t    r;
    int          nbytes;
    int unsigned base;
    logic        sign;
    nbytes  = 1 << op[1:0];
    base    = addr[9:0];
    r.store = op[3];
    r.addr  = addr;
    r.err   = (addr >= 32'd1024);
    r.be    = '0;
    r.data  = '0;
    for (int i = 0; i < nbytes; i++) r.be[addr[1:0] + i] = 1'b1;
    if (op[3]) begin
      for (int i = 0; i < 4; i++) r.data[8*i +: 8] = wdata[8*(i % nbytes) +: 8];
      if (!r.err) begin
        for (int i = 0; i < nbytes; i++) mirror[base + i] = wdata[8*i +: 8];
      end
    end else if (!r.err) begin
      for (int i = 0; i < nbytes; i++) r.data[8*i +: 8] = mirror[base + i];
      sign = ~op[2] & r.data[8*nbytes-1];
      for (int i = nbytes; i < 4; i++) r.data[8*i +: 8] = {8{sign}};
    end
    return r;
  endfunction

  function automatic bit cmd_is_legal(input logic [3:0] op, input logic [31:0] addr);
    bit op_ok;
    op_ok = op inside {LSU_LB, LSU_LH, LSU_LW, LSU_LBU, LSU_LHU, LSU_SB, LSU_SH, LSU_SW};
    if (op[1:0] == 2'b01) return op_ok && !addr[0];
    if (op[1:0] == 2'b10) return op_ok && (addr[1:0] == 2'b00);
    return op_ok;
  endfunction

  // ====================
  // Stimulus helpers
  // ====================
  task automatic wait_for_room();
    int cycles;
    cycles = 0;
    while (exp_q.size() >= QueueDepth && cycles < 100) begin
      @(posedge clk_i);
      cmd_valid_i <= 1'b0;
      cycles++;
    end
    assert (exp_q.size() < QueueDepth) else begin
      other_errors++;
      $display("ERROR %0t: timed out waiting for pending results to retire", $time);
    end
  endtask

  task automatic send_cmd(input logic [3:0] op, input logic [31:0] addr,
                          input logic [31:0] wdata, input bit burst = 1'b0,
                          input bit dropped = 1'b0);
    if (!burst) wait_for_room();
    @(posedge clk_i);
    cmd_valid_i <= 1'b1;
    cmd_op_i    <= lsu_op_e'(op);
    cmd_addr_i  <= addr;
    cmd_wdata_i <= wdata;
    if (!cmd_is_legal(op, addr)) begin
      rejects_expected++;
    end else if (dropped) begin
      overflows_expected++;
    end else begin
      exp_q.push_back(expected_result(op, addr, wdata));
    end
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    while (exp_q.size() != 0 && cycles < 400) begin
      @(posedge clk_i);
      cycles++;
    end
    assert (exp_q.size() == 0) else begin
      other_errors++;
      $display("ERROR %0t: timed out with %0d results still missing", $time, exp_q.size());
      exp_q.delete();
    end
    repeat (4) @(posedge clk_i);
  endtask

  task automatic check_counts();
    assert (rejects_seen == rejects_expected) else begin
      other_errors++;
      $display("ERROR %0t: saw %0d command rejects but expected %0d",
               $time, rejects_seen, rejects_expected);
    end
    assert (overflows_seen == overflows_expected) else begin
      other_errors++;
      $display("ERROR %0t: saw %0d queue overflows but expected %0d",
               $time, overflows_seen, overflows_expected);
    end
  endtask

  // ====================
  // Result checker
  // ====================
  task automatic compare_field(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      value_errors++;
      $display("FAIL %0t %s: got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_result();
    exp_res_t e;
    assert (exp_q.size() != 0) else begin
      other_errors++;
      $display("ERROR %0t: a result retired at %h with no command pending", $time, res_addr_o);
    end
    if (exp_q.size() != 0) begin
      e = exp_q.pop_front();
      compare_field("res_store_o", 32'(res_store_o), 32'(e.store));
      compare_field("res_addr_o", res_addr_o, e.addr);
      compare_field("res_be_o", 32'(res_be_o), 32'(e.be));
      compare_field("res_data_o", res_data_o, e.data);
      compare_field("res_err_o", 32'(res_err_o), 32'(e.err));
    end
  endtask

  // Outputs are sampled on the falling edge, half a cycle after they change.
  always @(negedge clk_i) begin
    if (rst_ni) begin
      if (cmd_reject_o) rejects_seen++;
      if (queue_overflow_o) overflows_seen++;
      if (res_valid_o) check_result();
    end
  end

  initial begin
    logic [31:0] r;
    logic [3:0]  op;
    logic [31:0] addr;
    cmd_valid_i = 1'b0;
    cmd_op_i    = LSU_LW;
    cmd_addr_i  = '0;
    cmd_wdata_i = '0;
    rst_ni      = 1'b0;
    for (int i = 0; i < 1024; i++) mirror[i] = 8'h00;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    assert (!res_valid_o && !cmd_reject_o && !queue_overflow_o) else begin
      other_errors++;
      $display("ERROR %0t: an output pulse is high during reset", $time);
    end
    @(posedge clk_i);
    rst_ni <= 1'b1;

    // Word stores fill the low region that later loads rely on.
    for (int w = 0; w < 64; w++) send_cmd(LSU_SW, 32'(w * 4), $random(seed));
    send_cmd(LSU_SW, 32'h3fc, 32'h5a5a_c3c3);
    for (int w = 0; w < 64; w++) send_cmd(LSU_LW, 32'(w * 4), 32'h0);
    send_cmd(LSU_LW, 32'h3fc, 32'h0);
    wait_drain();

    // Byte and halfword lanes with sign and zero extension.
    send_cmd(LSU_SW, 32'h40, 32'h0000_0000);
    send_cmd(LSU_SB, 32'h41, 32'h0000_0080);
    send_cmd(LSU_SH, 32'h42, 32'h1234_8001);
    send_cmd(LSU_SB, 32'h44, 32'hffff_ff7f);
    send_cmd(LSU_LB, 32'h41, 32'h0);
    send_cmd(LSU_LBU, 32'h41, 32'h0);
    send_cmd(LSU_LH, 32'h42, 32'h0);
    send_cmd(LSU_LHU, 32'h42, 32'h0);
    send_cmd(LSU_LB, 32'h44, 32'h0);
    send_cmd(LSU_LW, 32'h40, 32'h0);
    wait_drain();

    // Misaligned and illegal commands, then a legal one.
    send_cmd(LSU_LH, 32'h11, 32'h0);
    send_cmd(LSU_LW, 32'h12, 32'h0);
    send_cmd(LSU_SW, 32'h21, 32'h1111_1111);
    send_cmd(LSU_SH, 32'h23, 32'h2222_2222);
    send_cmd(4'b0011, 32'h20, 32'h0);
    send_cmd(4'b1100, 32'h20, 32'h0);
    send_cmd(4'b0111, 32'h20, 32'h0);
    send_cmd(LSU_LW, 32'h20, 32'h0);
    wait_drain();
    check_counts();

    // Out-of-range accesses alias onto word 0x10 but must not write it.
    send_cmd(LSU_SW, 32'h410, 32'hdead_beef);
    send_cmd(LSU_LW, 32'h410, 32'h0);
    send_cmd(LSU_LB, 32'h803, 32'h0);
    send_cmd(LSU_LW, 32'h10, 32'h0);
    wait_drain();

    // Random legal traffic, held to QueueDepth pending commands.
    for (int n = 0; n < 48; n++) begin
      r    = $random(seed);
      op   = legal_ops[r[2:0]];
      addr = {24'h0, r[15:8]};
      if (op[1:0] == 2'b01) addr[0] = 1'b0;
      if (op[1:0] == 2'b10) addr[1:0] = 2'b00;
      if (r[31:29] == 3'b000) addr[10] = 1'b1;
      send_cmd(op, addr, $random(seed));
    end
    wait_drain();
    check_counts();

    // The queue drains one access every two cycles, so the seventh command
    // after the store finds it full and is dropped.
    send_cmd(LSU_SW, 32'h80, 32'h0bad_f00d, 1'b1);
    send_cmd(LSU_LW, 32'h84, 32'h0, 1'b1);
    send_cmd(LSU_SB, 32'h85, 32'h0000_007f, 1'b1);
    send_cmd(LSU_LH, 32'h86, 32'h0, 1'b1);
    send_cmd(LSU_SH, 32'h88, 32'h0000_c3c3, 1'b1);
    send_cmd(LSU_LBU, 32'h80, 32'h0, 1'b1);
    send_cmd(LSU_LW, 32'h88, 32'h0, 1'b1);
    send_cmd(LSU_SW, 32'h84, 32'hffff_ffff, 1'b1, 1'b1);
    wait_drain();
    send_cmd(LSU_LW, 32'h84, 32'h0);
    wait_drain();
    check_counts();

    $display("Checks done: %0d value errors, %0d other errors", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
common/dmem_pkg.sv
rtl/lsu_cmd_decode.sv
lsu/lsu_issue_queue.sv
lsu/lsu_access_tracker.sv
rtl/data_ram.sv
rtl/lsu_subsystem_top.sv
verification/tb_lsu_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the load/store subsystem testbench with Verilator and runs it.
# The exit status is set by a search for the pass line in the simulation output.

cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f --top-module tb_lsu_subsystem &&
  ./obj_dir/Vtb_lsu_subsystem | tee /dev/stderr | grep -x "STATUS: PASS" > /dev/null &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
